// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	decode_if.consumer           dec,
	input  wire core_pkg::word_t src1,
	input  wire core_pkg::word_t src2,
	output core_pkg::word_t      result,
	output logic                 overflow
);

	logic [32:0]     add_out;  // {overflow, sum}
	logic [32:0]     sub_out;
	logic [32:0]     rsub_out;
	logic [4:0]      shamt;
	core_pkg::word_t rotated;

	// Overflow is the carry into bit 31 xor the carry out of it
	function automatic logic [32:0] add_ovf(
		input core_pkg::word_t x,
		input core_pkg::word_t y,
		input logic            sub
	);
		core_pkg::word_t yy;
		core_pkg::word_t s;
		logic            c_in31;
		logic            c_out;
		yy = sub ? ~y : y;
		{c_in31, s[30:0]} = {1'b0, x[30:0]} + {1'b0, yy[30:0]} + {31'b0, sub};
		{c_out, s[31]} = {1'b0, x[31]} + {1'b0, yy[31]} + {1'b0, c_in31};
		return {c_in31 ^ c_out, s};
	endfunction

	assign add_out  = add_ovf(src1, src2, 1'b0);
	assign sub_out  = add_ovf(src1, src2, 1'b1);
	assign rsub_out = add_ovf(src2, src1, 1'b1); // SUBRI takes imm minus ra

	assign shamt   = src2[4:0];
	assign rotated = (src1 >> shamt) | (src1 << (6'd32 - {1'b0, shamt}));

	always_comb begin
		result   = '0;
		overflow = 1'b0;
		case (dec.opcode)
			isa_pkg::OP_BASE: begin
				case (dec.sub_op)
					isa_pkg::SUB_ADD: {overflow, result} = add_out;
					isa_pkg::SUB_SUB: {overflow, result} = sub_out;
					isa_pkg::SUB_AND: result = src1 & src2;
					isa_pkg::SUB_OR:  result = src1 | src2;
					isa_pkg::SUB_XOR: result = src1 ^ src2;
					isa_pkg::SUB_SLT: result = {31'b0, src1 < src2};
					isa_pkg::SUB_SLTS: result = {31'b0, $signed(src1) < $signed(src2)};
					isa_pkg::SUB_SRL, isa_pkg::SUB_SRLI: result = src1 >> shamt;
					isa_pkg::SUB_SLL, isa_pkg::SUB_SLLI: result = src1 << shamt;
					isa_pkg::SUB_ROTRI: result = rotated;
					default: result = '0;
				endcase
			end
			isa_pkg::OP_ADDI:  {overflow, result} = add_out;
			isa_pkg::OP_SUBRI: {overflow, result} = rsub_out;
			isa_pkg::OP_ANDI:  result = src1 & src2;
			isa_pkg::OP_ORI:   result = src1 | src2;
			isa_pkg::OP_XORI:  result = src1 ^ src2;
			isa_pkg::OP_SLTI:  result = {31'b0, src1 < src2};
			isa_pkg::OP_SLTSI: result = {31'b0, $signed(src1) < $signed(src2)};
			isa_pkg::OP_LWI, isa_pkg::OP_SWI: begin
				result = add_out[31:0]; // Address only, no overflow report
			end
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

	typedef logic [31:0] word_t;     // Datapath word
	typedef logic [4:0]  reg_addr_t; // Register index

	localparam int NUM_REGS = 32;

endpackage

`default_nettype wire

// File: decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

	logic                valid;
	isa_pkg::opcode_t    opcode;
	isa_pkg::sub_op_t    sub_op;
	core_pkg::reg_addr_t rd;
	core_pkg::reg_addr_t ra;
	core_pkg::reg_addr_t rb;
	core_pkg::word_t     imm;       // Already extended
	logic                use_imm;
	logic                writes_rd;
	logic                is_load;
	logic                is_store;
	logic                illegal;

	modport producer (
		output valid, opcode, sub_op, rd, ra, rb, imm,
		output use_imm, writes_rd, is_load, is_store, illegal
	);

	modport consumer (
		input valid, opcode, sub_op, rd, ra, rb, imm,
		input use_imm, writes_rd, is_load, is_store, illegal
	);

endinterface

`default_nettype wire

// File: execute_stimulus.txt
# instr    kind  value     ovf  store_data   (all hex)
# kind: R result, L load address, S store address and data, I illegal
58101234 R 00001234 0 00000000
58200F0F R 00000F0F 0 00000000
40308800 R 00002143 0 00000000
40418401 R 00000F0F 0 00000000
40508802 R 00000204 0 00000000
40608804 R 00001F3F 0 00000000
40731403 R 00001D3B 0 00000000
58807FFF R 00007FFF 0 00000000
40944008 R 7FFF0000 0 00000000
40A4A400 R FFFE0000 1 00000000
52B08005 R FFFFEDD1 0 00000000
40C50406 R 00000000 0 00000000
40D50407 R 00000001 0 00000000
5CE0F000 R 00000001 0 00000000
5EF0F000 R 00000000 0 00000000
59000024 R 00000024 0 00000000
4114C00D R 07FFF000 0 00000000
4120C00C R 00012340 0 00000000
41357C09 R 00000001 0 00000000
4140A00B R 34000012 0 00000000
0420FFFC L 00001230 0 00000000
14708010 S 00001244 0 00001D3B
41510004 R 00000F0F 0 00000000
7E10FFFF I 00000000 0 00000000
4010801F I 00000000 0 00000000
41708004 R 00001234 0 00000000

// File: execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire logic            instr_valid,
	input  wire core_pkg::word_t instr,
	output logic                 result_valid,
	output core_pkg::word_t      result,
	output logic                 overflow,
	output logic                 mem_read,
	output logic                 mem_write,
	output core_pkg::word_t      mem_addr,
	output core_pkg::word_t      mem_wdata,
	output logic                 illegal_instr
);

	decode_if dec_bus ();

	core_pkg::reg_addr_t rd_addr_b;
	core_pkg::word_t     rd_data_a;
	core_pkg::word_t     rd_data_b;
	core_pkg::word_t     src2;
	core_pkg::word_t     alu_result;
	logic                alu_overflow;
	logic                wr_en;
	core_pkg::reg_addr_t wr_addr;
	core_pkg::word_t     wr_data;

	// Stores read their data register through port b
	assign rd_addr_b = dec_bus.is_store ? dec_bus.rd : dec_bus.rb;
	assign src2      = dec_bus.use_imm ? dec_bus.imm : rd_data_b;

	instr_decoder u_decoder (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dec         (dec_bus)
	);

	register_file u_regfile (
		.clk       (clk),
		.reset     (reset),
		.rd_addr_a (dec_bus.ra),
		.rd_addr_b (rd_addr_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	alu u_alu (
		.dec      (dec_bus),
		.src1     (rd_data_a),
		.src2     (src2),
		.result   (alu_result),
		.overflow (alu_overflow)
	);

	writeback_stage u_writeback (
		.clk           (clk),
		.reset         (reset),
		.dec           (dec_bus),
		.alu_result    (alu_result),
		.alu_overflow  (alu_overflow),
		.store_src     (rd_data_b),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.result_valid  (result_valid),
		.result        (result),
		.overflow      (overflow),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.illegal_instr (illegal_instr)
	);

endmodule

`default_nettype wire

// File: execute_unit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit_sva (
	input wire logic clk,
	input wire logic reset,
	input wire logic instr_valid,
	input wire logic result_valid,
	input wire logic overflow,
	input wire logic mem_read,
	input wire logic mem_write,
	input wire logic illegal_instr
);

	logic any_strobe;

	assign any_strobe = result_valid || mem_read || mem_write || illegal_instr;

	one_strobe_at_most: assert property (@(posedge clk) disable iff (reset)
		$onehot0({result_valid, mem_read, mem_write, illegal_instr}))
		else $error("More than one output strobe in the same cycle");

	// Two cycles of latency, one strobe per instruction
	strobe_follows_valid: assert property (@(posedge clk) disable iff (reset)
		any_strobe == $past(instr_valid, 2))
		else $error("Output strobe does not match instr_valid two cycles earlier");

	overflow_with_result: assert property (@(posedge clk) disable iff (reset)
		overflow |-> result_valid)
		else $error("Overflow is high without result_valid");

endmodule

bind execute_unit execute_unit_sva u_sva (
	.clk           (clk),
	.reset         (reset),
	.instr_valid   (instr_valid),
	.result_valid  (result_valid),
	.overflow      (overflow),
	.mem_read      (mem_read),
	.mem_write     (mem_write),
	.illegal_instr (illegal_instr)
);

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire logic            instr_valid,
	input  wire core_pkg::word_t instr,
	decode_if.producer           dec
);

	logic             valid_q;
	core_pkg::word_t  instr_q;
	isa_pkg::opcode_t opcode;
	isa_pkg::sub_op_t sub_op;
	core_pkg::word_t  imm_sext;
	core_pkg::word_t  imm_zext;
	core_pkg::word_t  shamt_zext;

	always_ff @(posedge clk) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= instr_valid;
	end

	always_ff @(posedge clk) begin
		if (instr_valid)
			instr_q <= instr;
	end

	assign opcode = instr_q[isa_pkg::OPCODE_LSB +: 6];
	assign sub_op = instr_q[4:0];

	assign imm_sext = {{($bits(core_pkg::word_t) - isa_pkg::IMM_WIDTH){instr_q[isa_pkg::IMM_WIDTH-1]}},
		instr_q[isa_pkg::IMM_WIDTH-1:0]};
	assign imm_zext = {{($bits(core_pkg::word_t) - isa_pkg::IMM_WIDTH){1'b0}},
		instr_q[isa_pkg::IMM_WIDTH-1:0]};
	assign shamt_zext = {27'b0, instr_q[isa_pkg::RB_LSB +: 5]}; // Shift immediate sits in rb

	assign dec.valid  = valid_q;
	assign dec.opcode = opcode;
	assign dec.sub_op = sub_op;
	assign dec.rd     = instr_q[isa_pkg::RD_LSB +: 5];
	assign dec.ra     = instr_q[isa_pkg::RA_LSB +: 5];
	assign dec.rb     = instr_q[isa_pkg::RB_LSB +: 5];

	always_comb begin
		dec.imm       = '0;
		dec.use_imm   = 1'b0;
		dec.writes_rd = 1'b0;
		dec.is_load   = 1'b0;
		dec.is_store  = 1'b0;
		dec.illegal   = 1'b0;
		case (opcode)
			isa_pkg::OP_BASE: begin
				case (sub_op)
					isa_pkg::SUB_ADD, isa_pkg::SUB_SUB, isa_pkg::SUB_AND,
					isa_pkg::SUB_OR, isa_pkg::SUB_XOR, isa_pkg::SUB_SLT,
					isa_pkg::SUB_SLTS, isa_pkg::SUB_SRL, isa_pkg::SUB_SLL: begin
						dec.writes_rd = 1'b1;
					end
					isa_pkg::SUB_SRLI, isa_pkg::SUB_SLLI, isa_pkg::SUB_ROTRI: begin
						dec.imm       = shamt_zext;
						dec.use_imm   = 1'b1;
						dec.writes_rd = 1'b1;
					end
					default: dec.illegal = 1'b1;
				endcase
			end
			isa_pkg::OP_ADDI, isa_pkg::OP_SUBRI, isa_pkg::OP_SLTI, isa_pkg::OP_SLTSI: begin
				dec.imm       = imm_sext;
				dec.use_imm   = 1'b1;
				dec.writes_rd = 1'b1;
			end
			isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI: begin
				dec.imm       = imm_zext; // Logic immediates are unsigned
				dec.use_imm   = 1'b1;
				dec.writes_rd = 1'b1;
			end
			isa_pkg::OP_LWI: begin
				dec.imm     = imm_sext;
				dec.use_imm = 1'b1;
				dec.is_load = 1'b1;
			end
			isa_pkg::OP_SWI: begin
				dec.imm      = imm_sext;
				dec.use_imm  = 1'b1;
				dec.is_store = 1'b1;
			end
			default: dec.illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [5:0] opcode_t;
	typedef logic [4:0] sub_op_t;

	// Major opcodes
	localparam opcode_t OP_BASE  = 6'b100000;
	localparam opcode_t OP_ADDI  = 6'b101000;
	localparam opcode_t OP_SUBRI = 6'b101001;
	localparam opcode_t OP_ANDI  = 6'b101010;
	localparam opcode_t OP_XORI  = 6'b101011;
	localparam opcode_t OP_ORI   = 6'b101100;
	localparam opcode_t OP_SLTI  = 6'b101110;
	localparam opcode_t OP_SLTSI = 6'b101111;
	localparam opcode_t OP_LWI   = 6'b000010;
	localparam opcode_t OP_SWI   = 6'b001010;

	// Base group sub-operations
	localparam sub_op_t SUB_ADD   = 5'b00000;
	localparam sub_op_t SUB_SUB   = 5'b00001;
	localparam sub_op_t SUB_AND   = 5'b00010;
	localparam sub_op_t SUB_XOR   = 5'b00011;
	localparam sub_op_t SUB_OR    = 5'b00100;
	localparam sub_op_t SUB_SLT   = 5'b00110;
	localparam sub_op_t SUB_SLTS  = 5'b00111;
	localparam sub_op_t SUB_SLLI  = 5'b01000;
	localparam sub_op_t SUB_SRLI  = 5'b01001;
	localparam sub_op_t SUB_ROTRI = 5'b01011;
	localparam sub_op_t SUB_SLL   = 5'b01100;
	localparam sub_op_t SUB_SRL   = 5'b01101;

	// Field positions within the instruction word
	localparam int OPCODE_LSB = 25;
	localparam int RD_LSB     = 20;
	localparam int RA_LSB     = 15;
	localparam int RB_LSB     = 10;
	localparam int IMM_WIDTH  = 15;

endpackage

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire core_pkg::reg_addr_t rd_addr_a,
	input  wire core_pkg::reg_addr_t rd_addr_b,
	input  wire logic                wr_en,
	input  wire core_pkg::reg_addr_t wr_addr,
	input  wire core_pkg::word_t     wr_data,
	output core_pkg::word_t          rd_data_a,
	output core_pkg::word_t          rd_data_b
);

	core_pkg::word_t regs [core_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < core_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data; // r0 is writable too
		end
	end

	// Reads see the previous edge's write, no bypass needed
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_execute_unit -f sources.f \
	&& ./obj_dir/Vtb_execute_unit \
	|| exit 1

// File: sources.f
core_pkg.sv
isa_pkg.sv
decode_if.sv
instr_decoder.sv
register_file.sv
alu.sv
writeback_stage.sv
execute_unit.sv
execute_unit_sva.sv
tb_execute_unit.sv

// File: tb_execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_execute_unit;

	localparam int STROBE_TIMEOUT = 20; // Cycles to wait for any output strobe

	logic            clk;
	logic            reset;
	logic            instr_valid;
	core_pkg::word_t instr;
	logic            result_valid;
	core_pkg::word_t result;
	logic            overflow;
	logic            mem_read;
	logic            mem_write;
	core_pkg::word_t mem_addr;
	core_pkg::word_t mem_wdata;
	logic            illegal_instr;

	core_pkg::word_t instr_list[$];
	logic [7:0]      kind_list[$];
	core_pkg::word_t value_list[$];
	core_pkg::word_t ovf_list[$];
	core_pkg::word_t wdata_list[$];

	execute_unit dut (
		.clk           (clk),
		.reset         (reset),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.result_valid  (result_valid),
		.result        (result),
		.overflow      (overflow),
		.mem_read      (mem_read),
		.mem_write     (mem_write),
		.mem_addr      (mem_addr),
		.mem_wdata     (mem_wdata),
		.illegal_instr (illegal_instr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input core_pkg::word_t actual,
		input core_pkg::word_t expected);
		if (actual !== expected)
			abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
				name, actual, expected));
	endtask

	task automatic load_stimulus;
		int              fd;
		int              n;
		string           line;
		core_pkg::word_t word;
		logic [7:0]      kind;
		core_pkg::word_t value;
		core_pkg::word_t ovf;
		core_pkg::word_t wdata;
		fd = $fopen("execute_stimulus.txt", "r");
		if (fd == 0)
			abort_run("Cannot open the stimulus file execute_stimulus.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin // Skip the column description
				n = $sscanf(line, "%h %c %h %h %h", word, kind, value, ovf, wdata);
				if (n == 5) begin
					if (kind != "R" && kind != "L" && kind != "S" && kind != "I")
						abort_run($sformatf("Unknown kind %c in the stimulus file", kind));
					instr_list.push_back(word);
					kind_list.push_back(kind);
					value_list.push_back(value);
					ovf_list.push_back(ovf);
					wdata_list.push_back(wdata);
				end
			end
		end
		$fclose(fd);
		if (instr_list.size() == 0)
			abort_run("The stimulus file holds no instructions");
	endtask

	// One instruction per cycle, so dependent instructions run back to back
	task automatic drive_instructions;
		foreach (instr_list[i]) begin
			@(posedge clk);
			instr_valid <= 1'b1;
			instr       <= instr_list[i];
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		instr       <= '0;
	endtask

	task automatic wait_strobe;
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!(result_valid || mem_read || mem_write || illegal_instr)) begin
			cycles++;
			if (cycles > STROBE_TIMEOUT)
				abort_run("Timed out waiting for an output strobe");
			@(negedge clk);
		end
	endtask

	task automatic compare_outcome(input int idx);
		logic [3:0] exp_strobes;
		exp_strobes = 4'b0000;
		case (kind_list[idx])
			"R": exp_strobes = 4'b1000;
			"L": exp_strobes = 4'b0100;
			"S": exp_strobes = 4'b0010;
			default: exp_strobes = 4'b0001;
		endcase
		// Order is result_valid, mem_read, mem_write, illegal_instr
		check_value("strobes", {28'b0, result_valid, mem_read, mem_write, illegal_instr},
			{28'b0, exp_strobes});
		if (kind_list[idx] == "R") begin
			check_value("result", result, value_list[idx]);
			check_value("overflow", {31'b0, overflow}, ovf_list[idx]);
		end
		if (kind_list[idx] == "L" || kind_list[idx] == "S")
			check_value("mem_addr", mem_addr, value_list[idx]);
		if (kind_list[idx] == "S")
			check_value("mem_wdata", mem_wdata, wdata_list[idx]);
	endtask

	task automatic collect_outcomes;
		for (int i = 0; i < instr_list.size(); i++) begin
			wait_strobe();
			compare_outcome(i);
		end
	endtask

	initial begin
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		load_stimulus();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		fork
			drive_instructions();
			collect_outcomes();
		join
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
	input  wire logic            clk,
	input  wire logic            reset,
	decode_if.consumer           dec,
	input  wire core_pkg::word_t alu_result,
	input  wire logic            alu_overflow,
	input  wire core_pkg::word_t store_src,
	output logic                 wr_en,
	output core_pkg::reg_addr_t  wr_addr,
	output core_pkg::word_t      wr_data,
	output logic                 result_valid,
	output core_pkg::word_t      result,
	output logic                 overflow,
	output logic                 mem_read,
	output logic                 mem_write,
	output core_pkg::word_t      mem_addr,
	output core_pkg::word_t      mem_wdata,
	output logic                 illegal_instr
);

	logic legal;

	assign legal = dec.valid && !dec.illegal;

	// Register file write lands on the same edge as the outcome register
	assign wr_en   = legal && dec.writes_rd;
	assign wr_addr = dec.rd;
	assign wr_data = alu_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid  <= 1'b0;
			overflow      <= 1'b0;
			mem_read      <= 1'b0;
			mem_write     <= 1'b0;
			illegal_instr <= 1'b0;
		end else begin
			result_valid  <= wr_en;
			overflow      <= wr_en && alu_overflow; // Only meaningful with a result
			mem_read      <= legal && dec.is_load;
			mem_write     <= legal && dec.is_store;
			illegal_instr <= dec.valid && dec.illegal;
		end
	end

	always_ff @(posedge clk) begin
		result    <= alu_result;
		mem_addr  <= alu_result;
		mem_wdata <= store_src;
	end

endmodule

`default_nettype wire
